// File: hdl/hps_io_pkg.sv
package hps_io_pkg;

	//////////////////////////////////////////////////////////////////////
	// bus words and command codes
	//////////////////////////////////////////////////////////////////////

	// one word on the host bus
	typedef logic [15:0] word_t;

	// first word of a transfer, low byte
	typedef enum logic [7:0] {
		CMD_CFG         = 8'h01,
		CMD_JOY0        = 8'h02,
		CMD_JOY1        = 8'h03,
		CMD_MOUSE       = 8'h04,
		CMD_KBD         = 8'h05,
		CMD_CONF_STR    = 8'h14,
		CMD_STATUS      = 8'h1e,
		CMD_PS2_HOST    = 8'h21,
		CMD_STATUS_SET  = 8'h29,
		CMD_FILE_TX     = 8'h53,
		CMD_FILE_TX_DAT = 8'h54,
		CMD_FILE_INDEX  = 8'h55,
		CMD_FILE_INFO   = 8'h56
	} cmd_e;

	// host side of the bus
	typedef struct packed {
		logic  enable;
		logic  strobe;
		word_t din;
	} hps_bus_t;

	//////////////////////////////////////////////////////////////////////
	// ps/2 channels
	//////////////////////////////////////////////////////////////////////

	// byte toward a port transmit queue
	typedef struct packed {
		logic       we;
		logic [7:0] wdata;
	} ps2_wr_t;

	// byte received from the host side of a port
	typedef struct packed {
		logic       has_data;
		logic [7:0] data;
	} ps2_rd_t;

	// clock and data pair, 1 is released
	typedef struct packed {
		logic clk;
		logic dat;
	} ps2_lines_t;

	typedef logic [31:0] joy_t;

	localparam int NUM_PS2   = 2;
	localparam int PS2_KBD   = 0;
	localparam int PS2_MOUSE = 1;

	// high byte marking a word that is not forwarded
	localparam logic [7:0] PS2_SKIP = 8'hFF;

	// upper nibble of the status_set first reply
	localparam logic [3:0] STSET_TAG = 4'hA;

	localparam int FILE_ADDR_W = 27;

endpackage

// File: hdl/hps_cmd_decoder.sv
module hps_cmd_decoder import hps_io_pkg::*; #(
	parameter int STRLEN = 1
) (
	input  logic                clk_sys,
	input  logic                reset,
	input  hps_bus_t            bus,
	input  logic [8*STRLEN-1:0] conf_str,
	input  logic [63:0]         status_in,
	input  logic                status_set,
	input  ps2_rd_t             ps2_rd [NUM_PS2],
	output word_t               io_dout,
	output logic [1:0]          buttons,
	output logic [63:0]         status,
	output joy_t                joystick [2],
	output ps2_wr_t             ps2_wr [NUM_PS2],
	output logic [NUM_PS2-1:0]  ps2_rdack
);

	localparam int CNT_W = 10;

	logic [CNT_W-1:0] byte_cnt;
	cmd_e             cmd;
	logic             ps2_skip;
	logic             status_set_q;
	logic [3:0]       stset_cnt;
	logic [63:0]      status_req;
	logic [1:0]       slot_idx;
	logic             slot_ok;

	// slots 1..4 address the four 16-bit quarters, low quarter first
	assign slot_idx = byte_cnt[1:0] - 2'd1;
	assign slot_ok  = (byte_cnt >= CNT_W'(1)) && (byte_cnt <= CNT_W'(4));

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			byte_cnt     <= '0;
			cmd          <= cmd_e'(8'h00);
			ps2_skip     <= 1'b0;
			status_set_q <= 1'b0;
			stset_cnt    <= '0;
			status_req   <= '0;
			io_dout      <= '0;
			buttons      <= '0;
			status       <= '0;
			joystick[0]  <= '0;
			joystick[1]  <= '0;
			ps2_rdack    <= '0;
			for (int i = 0; i < NUM_PS2; i++) begin
				ps2_wr[i] <= '0;
			end
		end else begin
			// one-cycle strobes toward the ports
			for (int i = 0; i < NUM_PS2; i++) begin
				ps2_wr[i].we <= 1'b0;
			end
			ps2_rdack <= '0;

			// core asks the host to pick up a new status word
			status_set_q <= status_set;
			if (status_set && !status_set_q) begin
				stset_cnt  <= stset_cnt + 4'd1;
				status_req <= status_in;
			end

			if (!bus.enable) begin
				byte_cnt <= '0;
				io_dout  <= '0;
				ps2_skip <= 1'b0;
			end else if (bus.strobe) begin
				io_dout <= '0;
				if (!(&byte_cnt))
					byte_cnt <= byte_cnt + 1'b1;

				if (byte_cnt == '0) begin
					cmd <= cmd_e'(bus.din[7:0]);
					if (bus.din[7:0] == CMD_STATUS_SET)
						io_dout <= {8'h00, STSET_TAG, stset_cnt};
				end else begin
					case (cmd)
						CMD_CFG: buttons <= bus.din[1:0];

						CMD_JOY0, CMD_JOY1: begin
							if (byte_cnt == CNT_W'(1))
								joystick[cmd == CMD_JOY1][15:0] <= bus.din;
							else if (byte_cnt == CNT_W'(2))
								joystick[cmd == CMD_JOY1][31:16] <= bus.din;
						end

						// bytes for the emulated devices, skip word ends the run
						CMD_KBD, CMD_MOUSE: begin
							if (bus.din[15:8] == PS2_SKIP) begin
								ps2_skip <= 1'b1;
							end else if (!ps2_skip) begin
								ps2_wr[(cmd == CMD_MOUSE) ? PS2_MOUSE : PS2_KBD] <=
									'{we: 1'b1, wdata: bus.din[7:0]};
							end
						end

						CMD_CONF_STR: begin
							if (byte_cnt <= STRLEN)
								io_dout[7:0] <= conf_str[(STRLEN - int'(byte_cnt)) * 8 +: 8];
						end

						CMD_STATUS: begin
							if (slot_ok)
								status[{slot_idx, 4'b0000} +: 16] <= bus.din;
						end

						CMD_STATUS_SET: begin
							if (slot_ok)
								io_dout <= status_req[{slot_idx, 4'b0000} +: 16];
						end

						// host side reads what the host lines sent us
						CMD_PS2_HOST: begin
							if (byte_cnt == CNT_W'(1)) begin
								io_dout              <= {7'd0, ps2_rd[PS2_KBD]};
								ps2_rdack[PS2_KBD]   <= 1'b1;
							end else if (byte_cnt == CNT_W'(2)) begin
								io_dout              <= {7'd0, ps2_rd[PS2_MOUSE]};
								ps2_rdack[PS2_MOUSE] <= 1'b1;
							end
						end

						default: ;
					endcase
				end
			end
		end
	end

endmodule

// File: hdl/ps2_port.sv
module ps2_port import hps_io_pkg::*; #(
	parameter int PS2DIV    = 4,
	parameter int FIFO_BITS = 5
) (
	input  logic       clk_sys,
	input  logic       reset,
	input  ps2_wr_t    wr,
	input  logic       rd,
	input  ps2_lines_t lines_in,
	output ps2_lines_t lines_out,
	output ps2_rd_t    rdata
);

	localparam int DIV_W = (PS2DIV > 1) ? $clog2(PS2DIV) : 1;

	logic [DIV_W-1:0]     div_cnt;
	logic                 ps2_clk;
	logic                 div_tick;
	logic                 clk_rise;
	logic                 clk_fall;

	logic [7:0]           fifo_mem [2**FIFO_BITS];
	logic [FIFO_BITS-1:0] wptr;
	logic [FIFO_BITS-1:0] rptr;
	logic [FIFO_BITS-1:0] wptr_next;
	logic                 fifo_empty;
	logic                 fifo_full;

	logic [3:0]           tx_state;
	logic [7:0]           tx_byte;
	logic                 parity;
	logic [2:0]           rx_state;
	logic [3:0]           rx_cnt;
	logic                 c1;
	logic                 c2;
	logic                 d1;

	//////////////////////////////////////////////////////////////////////
	// device clock, half period of PS2DIV cycles
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			div_cnt <= '0;
			ps2_clk <= 1'b0;
		end else if (div_tick) begin
			div_cnt <= '0;
			ps2_clk <= ~ps2_clk;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign div_tick = (div_cnt == DIV_W'(PS2DIV - 1));
	assign clk_rise = div_tick && !ps2_clk;
	assign clk_fall = div_tick && ps2_clk;

	// transmit queue
	assign wptr_next  = wptr + 1'b1;
	assign fifo_empty = (wptr == rptr);
	assign fifo_full  = (wptr_next == rptr);

	always_ff @(posedge clk_sys) begin
		if (wr.we && !fifo_full)
			fifo_mem[wptr] <= wr.wdata;
	end

	//////////////////////////////////////////////////////////////////////
	// frame engine
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			wptr      <= '0;
			rptr      <= '0;
			tx_state  <= '0;
			tx_byte   <= '0;
			parity    <= 1'b0;
			rx_state  <= '0;
			rx_cnt    <= '0;
			c1        <= 1'b1;
			c2        <= 1'b1;
			d1        <= 1'b1;
			lines_out <= '{clk: 1'b1, dat: 1'b1};
			rdata     <= '0;
		end else begin
			if (wr.we && !fifo_full)
				wptr <= wptr_next;
			if (rd)
				rdata.has_data <= 1'b0;

			c1 <= lines_in.clk;
			c2 <= c1;
			d1 <= lines_in.dat;

			// host request: clock released while data held low
			if (rx_state == '0 && tx_state == '0 && !c2 && c1 && !d1) begin
				rx_state      <= 3'd1;
				lines_out.dat <= 1'b1;
			end

			if (clk_rise) begin
				lines_out.clk <= 1'b1;
				if (rx_state != '0) begin
					case (rx_state)
						3'd1: begin
							rx_state <= 3'd2;
							rx_cnt   <= '0;
						end
						// eight data bits, then the parity slot is passed over
						3'd2: begin
							if (rx_cnt < 4'd8)
								rdata.data <= {d1, rdata.data[7:1]};
							else
								rx_state <= 3'd3;
							rx_cnt <= rx_cnt + 4'd1;
						end
						// stop bit seen, drive ack
						3'd3: begin
							if (d1) begin
								rx_state      <= 3'd4;
								lines_out.dat <= 1'b0;
							end
						end
						default: begin
							lines_out.dat  <= 1'b1;
							rdata.has_data <= 1'b1;
							rx_state       <= '0;
						end
					endcase
				end else if (tx_state == '0) begin
					// lines idle and something queued: put the start bit out
					if (c2 && c1 && d1 && !fifo_empty) begin
						tx_byte       <= fifo_mem[rptr];
						rptr          <= rptr + 1'b1;
						parity        <= 1'b1;
						tx_state      <= 4'd1;
						lines_out.dat <= 1'b0;
					end
				end else begin
					if (tx_state <= 4'd8) begin
						lines_out.dat <= tx_byte[0];
						tx_byte       <= {1'b0, tx_byte[7:1]};
						if (tx_byte[0])
							parity <= ~parity;
					end else if (tx_state == 4'd9) begin
						lines_out.dat <= parity;
					end else if (tx_state == 4'd10) begin
						lines_out.dat <= 1'b1;
					end
					tx_state <= (tx_state == 4'd11) ? 4'd0 : tx_state + 4'd1;
				end
			end

			// clock only pulses low while a frame is in flight
			if (clk_fall)
				lines_out.clk <= (tx_state == '0) && (rx_state < 3'd2);
		end
	end

endmodule

// File: hdl/file_loader.sv
module file_loader import hps_io_pkg::*; #(
	parameter int WIDE = 0
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  hps_bus_t               bus,
	output logic                   ioctl_download,
	output logic [7:0]             ioctl_index,
	output logic [31:0]            ioctl_file_ext,
	output logic                   ioctl_wr,
	output logic [FILE_ADDR_W-1:0] ioctl_addr,
	output logic [15:0]            ioctl_dout
);

	// 16-bit downloads step by bytes, two at a time
	localparam logic [FILE_ADDR_W-1:0] ADDR_STEP = (WIDE != 0) ? 2 : 1;

	logic                   has_cmd;
	cmd_e                   cmd;
	logic [1:0]             info_cnt;
	logic [FILE_ADDR_W-1:0] addr;
	logic                   wr_pend;
	logic [FILE_ADDR_W-1:0] wr_addr;
	word_t                  wr_data;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			has_cmd        <= 1'b0;
			cmd            <= cmd_e'(8'h00);
			info_cnt       <= '0;
			addr           <= '0;
			wr_pend        <= 1'b0;
			wr_addr        <= '0;
			wr_data        <= '0;
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_file_ext <= '0;
			ioctl_wr       <= 1'b0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
		end else begin
			// second stage of the write, address and data travel with the pulse
			ioctl_wr <= wr_pend;
			wr_pend  <= 1'b0;
			if (wr_pend) begin
				ioctl_addr <= wr_addr;
				ioctl_dout <= wr_data;
			end

			if (!bus.enable) begin
				has_cmd <= 1'b0;
			end else if (bus.strobe) begin
				if (!has_cmd) begin
					cmd      <= cmd_e'(bus.din[7:0]);
					has_cmd  <= 1'b1;
					info_cnt <= '0;
				end else begin
					case (cmd)
						// extension arrives high half first
						CMD_FILE_INFO: begin
							if (!info_cnt[1]) begin
								if (info_cnt == 2'd0)
									ioctl_file_ext[31:16] <= bus.din;
								else
									ioctl_file_ext[15:0] <= bus.din;
								info_cnt <= info_cnt + 2'd1;
							end
						end

						CMD_FILE_INDEX: ioctl_index <= bus.din[7:0];

						CMD_FILE_TX: begin
							if (|bus.din[7:0]) begin
								addr           <= '0;
								ioctl_download <= 1'b1;
							end else begin
								ioctl_addr     <= addr;
								ioctl_download <= 1'b0;
							end
						end

						CMD_FILE_TX_DAT: begin
							wr_addr <= addr;
							wr_data <= (WIDE != 0) ? bus.din : {8'h00, bus.din[7:0]};
							wr_pend <= 1'b1;
							addr    <= addr + ADDR_STEP;
						end

						default: ;
					endcase
				end
			end
		end
	end

endmodule

// File: hdl/hps_io.sv
module hps_io import hps_io_pkg::*; #(
	parameter int STRLEN = 1,
	parameter int WIDE   = 0,
	parameter int PS2DIV = 4
) (
	input  logic                   clk_sys,
	input  logic                   reset,

	// host bus
	input  logic                   io_enable,
	input  logic                   io_strobe,
	input  word_t                  io_din,
	output word_t                  io_dout,
	output logic                   io_wait,
	input  logic                   ioctl_wait,

	input  logic [8*STRLEN-1:0]    conf_str,
	input  logic [63:0]            status_in,
	input  logic                   status_set,
	output logic [1:0]             buttons,
	output logic [63:0]            status,
	output joy_t                   joystick_0,
	output joy_t                   joystick_1,

	// emulated keyboard and mouse
	input  logic                   ps2_kbd_clk_in,
	input  logic                   ps2_kbd_data_in,
	output logic                   ps2_kbd_clk_out,
	output logic                   ps2_kbd_data_out,
	input  logic                   ps2_mouse_clk_in,
	input  logic                   ps2_mouse_data_in,
	output logic                   ps2_mouse_clk_out,
	output logic                   ps2_mouse_data_out,

	// download
	output logic                   ioctl_download,
	output logic [7:0]             ioctl_index,
	output logic [31:0]            ioctl_file_ext,
	output logic                   ioctl_wr,
	output logic [FILE_ADDR_W-1:0] ioctl_addr,
	output logic [15:0]            ioctl_dout
);

	localparam int PS2_FIFO_BITS = 5;

	hps_bus_t           bus;
	joy_t               joystick [2];
	ps2_wr_t            ps2_wr [NUM_PS2];
	ps2_rd_t            ps2_rd [NUM_PS2];
	logic [NUM_PS2-1:0] ps2_rdack;
	ps2_lines_t         lines_in [NUM_PS2];
	ps2_lines_t         lines_out [NUM_PS2];

	assign bus     = '{enable: io_enable, strobe: io_strobe, din: io_din};
	assign io_wait = ioctl_wait;

	assign joystick_0 = joystick[0];
	assign joystick_1 = joystick[1];

	assign lines_in[PS2_KBD]   = '{clk: ps2_kbd_clk_in, dat: ps2_kbd_data_in};
	assign lines_in[PS2_MOUSE] = '{clk: ps2_mouse_clk_in, dat: ps2_mouse_data_in};

	assign ps2_kbd_clk_out    = lines_out[PS2_KBD].clk;
	assign ps2_kbd_data_out   = lines_out[PS2_KBD].dat;
	assign ps2_mouse_clk_out  = lines_out[PS2_MOUSE].clk;
	assign ps2_mouse_data_out = lines_out[PS2_MOUSE].dat;

	hps_cmd_decoder #(
		.STRLEN(STRLEN)
	) decoder_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.bus       (bus),
		.conf_str  (conf_str),
		.status_in (status_in),
		.status_set(status_set),
		.ps2_rd    (ps2_rd),
		.io_dout   (io_dout),
		.buttons   (buttons),
		.status    (status),
		.joystick  (joystick),
		.ps2_wr    (ps2_wr),
		.ps2_rdack (ps2_rdack)
	);

	// port 0 keyboard, port 1 mouse
	for (genvar i = 0; i < NUM_PS2; i++) begin : g_ps2
		ps2_port #(
			.PS2DIV   (PS2DIV),
			.FIFO_BITS(PS2_FIFO_BITS)
		) port_i (
			.clk_sys  (clk_sys),
			.reset    (reset),
			.wr       (ps2_wr[i]),
			.rd       (ps2_rdack[i]),
			.lines_in (lines_in[i]),
			.lines_out(lines_out[i]),
			.rdata    (ps2_rd[i])
		);
	end

	file_loader #(
		.WIDE(WIDE)
	) loader_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.bus           (bus),
		.ioctl_download(ioctl_download),
		.ioctl_index   (ioctl_index),
		.ioctl_file_ext(ioctl_file_ext),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout)
	);

endmodule

// File: bench/hps_host_tasks.svh
`ifndef HPS_HOST_TASKS_SVH
`define HPS_HOST_TASKS_SVH

// host side of the bus, every task starts and ends on a falling clock edge

task automatic begin_xfer();
	io_enable = 1'b1;
	@(negedge clk_sys);
endtask

task automatic end_xfer();
	io_enable = 1'b0;
	@(negedge clk_sys);
endtask

// one strobed word; the reply is checked on the edge after the one that took it
task automatic bus_word(input word_t w, input logic check, input word_t exp);
	io_strobe = 1'b1;
	io_din    = w;
	words_sent++;
	@(negedge clk_sys);
	io_strobe = 1'b0;
	dout_chk  = check;
	dout_exp  = exp;
	@(negedge clk_sys);
	dout_chk  = 1'b0;
endtask

task automatic send_word(input word_t w);
	bus_word(w, 1'b0, '0);
endtask

task automatic read_word(input word_t w, input word_t exp);
	bus_word(w, 1'b1, exp);
endtask

//////////////////////////////////////////////////////////////////////
// ps/2 line activity
//////////////////////////////////////////////////////////////////////

// frame from the keyboard port, data read while its clock is low
task automatic recv_kbd_frame(output logic [10:0] frame);
	for (int i = 0; i < 11; i++) begin
		@(negedge ps2_kbd_clk_out);
		@(negedge clk_sys);
		frame[i] = ps2_kbd_data_out;
	end
endtask

// host to device frame on the mouse lines
task automatic send_mouse_frame(input logic [7:0] b);
	logic [9:0] bits;
	bits = {1'b1, ~^b, b};
	// request to send: clock low, data low, then clock released
	ps2_mouse_clk_in = 1'b0;
	repeat (4) @(negedge clk_sys);
	ps2_mouse_data_in = 1'b0;
	repeat (4) @(negedge clk_sys);
	ps2_mouse_clk_in = 1'b1;
	// data bits, parity and stop, changed while the device clock is low
	for (int i = 0; i < 10; i++) begin
		@(negedge ps2_mouse_clk_out);
		@(negedge clk_sys);
		ps2_mouse_data_in = bits[i];
	end
	// device ack, byte is stored when it lets go of data
	@(negedge ps2_mouse_data_out);
	@(posedge ps2_mouse_data_out);
	@(negedge clk_sys);
endtask

`endif

// File: bench/tb_hps_io.sv
module tb_hps_io import hps_io_pkg::*; ();

	localparam int STRLEN         = 4;
	// well above the length of the whole sequence
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int QUIET_CYCLES   = 100;

	logic                   clk_sys;
	logic                   reset;
	logic                   io_enable;
	logic                   io_strobe;
	word_t                  io_din;
	word_t                  io_dout;
	logic                   io_wait;
	logic                   ioctl_wait;
	logic [8*STRLEN-1:0]    conf_str;
	logic [63:0]            status_in;
	logic                   status_set;
	logic [1:0]             buttons;
	logic [63:0]            status;
	joy_t                   joystick_0;
	joy_t                   joystick_1;
	logic                   ps2_kbd_clk_in;
	logic                   ps2_kbd_data_in;
	logic                   ps2_kbd_clk_out;
	logic                   ps2_kbd_data_out;
	logic                   ps2_mouse_clk_in;
	logic                   ps2_mouse_data_in;
	logic                   ps2_mouse_clk_out;
	logic                   ps2_mouse_data_out;
	logic                   ioctl_download;
	logic [7:0]             ioctl_index;
	logic [31:0]            ioctl_file_ext;
	logic                   ioctl_wr;
	logic [FILE_ADDR_W-1:0] ioctl_addr;
	logic [15:0]            ioctl_dout;

	// expected state kept by the bench
	string                  conf_text = "ABCD";
	integer                 seed = 32'hbefb_ee8b;
	int                     errors;
	int                     words_sent;
	int                     cycles;
	logic                   reg_chk;
	logic [1:0]             exp_buttons;
	joy_t                   exp_joy [2];
	logic [63:0]            exp_status;
	logic                   exp_download;
	logic [7:0]             exp_index;
	logic [31:0]            exp_ext;
	logic                   dout_chk;
	word_t                  dout_exp;
	logic                   dat_mode;
	logic                   dat_strobe;
	logic [FILE_ADDR_W-1:0] exp_addr;
	logic [15:0]            exp_data;
	logic                   frame_chk;
	logic [10:0]            rx_frame;
	logic [10:0]            exp_frame;
	logic                   quiet_chk;

	assign dat_strobe = dat_mode && io_enable && io_strobe;

	hps_io #(
		.STRLEN(STRLEN),
		.WIDE  (0),
		.PS2DIV(4)
	) dut_i (.*);

	`include "hps_host_tasks.svh"

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	task automatic check_regs();
		reg_chk = 1'b1;
		@(negedge clk_sys);
		reg_chk = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	assert property (@(posedge clk_sys) disable iff (reset)
		reg_chk |-> (buttons == exp_buttons && status == exp_status))
		else begin
			errors++;
			$display("error at %0t: buttons %h status %h, expected %h %h", $time,
				$sampled(buttons), $sampled(status), exp_buttons, exp_status);
		end

	assert property (@(posedge clk_sys) disable iff (reset)
		reg_chk |-> (joystick_0 == exp_joy[0] && joystick_1 == exp_joy[1]))
		else begin
			errors++;
			$display("error at %0t: joysticks %h %h, expected %h %h", $time,
				$sampled(joystick_0), $sampled(joystick_1), exp_joy[0], exp_joy[1]);
		end

	assert property (@(posedge clk_sys) disable iff (reset)
		reg_chk |-> (ioctl_download == exp_download))
		else begin
			errors++;
			$display("error at %0t: ioctl_download %b, expected %b", $time,
				$sampled(ioctl_download), exp_download);
		end

	assert property (@(posedge clk_sys) disable iff (reset)
		reg_chk |-> (ioctl_index == exp_index && ioctl_file_ext == exp_ext))
		else begin
			errors++;
			$display("error at %0t: index %h extension %h, expected %h %h", $time,
				$sampled(ioctl_index), $sampled(ioctl_file_ext), exp_index, exp_ext);
		end

	assert property (@(posedge clk_sys) disable iff (reset)
		reg_chk |-> (io_wait == ioctl_wait))
		else begin
			errors++;
			$display("error at %0t: io_wait %b, expected %b", $time,
				$sampled(io_wait), $sampled(ioctl_wait));
		end

	assert property (@(posedge clk_sys) disable iff (reset)
		dout_chk |-> (io_dout == dout_exp))
		else begin
			errors++;
			$display("error at %0t: io_dout %h, expected %h", $time,
				$sampled(io_dout), dout_exp);
		end

	// write pulse exactly two edges after its data strobe
	assert property (@(posedge clk_sys) disable iff (reset)
		$past(dat_strobe, 2) |-> (ioctl_wr && ioctl_addr == $past(exp_addr, 2) &&
			ioctl_dout == $past(exp_data, 2)))
		else begin
			errors++;
			$display("error at %0t: write %b addr %h data %h, expected addr %h data %h",
				$time, $sampled(ioctl_wr), $sampled(ioctl_addr), $sampled(ioctl_dout),
				$past(exp_addr, 2), $past(exp_data, 2));
		end

	assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |-> $past(dat_strobe, 2))
		else begin
			errors++;
			$display("ioctl_wr pulsed at %0t without a data word before it", $time);
		end

	assert property (@(posedge clk_sys) disable iff (reset)
		frame_chk |-> (rx_frame == exp_frame))
		else begin
			errors++;
			$display("error at %0t: keyboard frame %b, expected %b", $time,
				rx_frame, exp_frame);
		end

	assert property (@(posedge clk_sys) disable iff (reset)
		quiet_chk |-> ps2_kbd_clk_out)
		else begin
			errors++;
			$display("keyboard started a frame at %0t after a skip word", $time);
		end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		word_t       w;
		word_t       lo;
		word_t       hi;
		logic [63:0] st_val;
		logic [7:0]  b;

		reset             = 1'b1;
		io_enable         = 1'b0;
		io_strobe         = 1'b0;
		io_din            = '0;
		ioctl_wait        = 1'b0;
		status_in         = '0;
		status_set        = 1'b0;
		ps2_kbd_clk_in    = 1'b1;
		ps2_kbd_data_in   = 1'b1;
		ps2_mouse_clk_in  = 1'b1;
		ps2_mouse_data_in = 1'b1;
		errors            = 0;
		words_sent        = 0;
		reg_chk           = 1'b0;
		exp_buttons       = '0;
		exp_joy[0]        = '0;
		exp_joy[1]        = '0;
		exp_status        = '0;
		exp_download      = 1'b0;
		exp_index         = '0;
		exp_ext           = '0;
		dout_chk          = 1'b0;
		dout_exp          = '0;
		dat_mode          = 1'b0;
		exp_addr          = '0;
		exp_data          = '0;
		frame_chk         = 1'b0;
		rx_frame          = '0;
		exp_frame         = '0;
		quiet_chk         = 1'b0;
		conf_str          = '0;
		for (int i = 0; i < STRLEN; i++)
			conf_str = (conf_str << 8) | conf_text[i];

		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		// cfg, joysticks and status words
		w = $random(seed);
		begin_xfer();
		send_word(CMD_CFG);
		send_word(w);
		end_xfer();
		exp_buttons = w[1:0];
		for (int j = 0; j < 2; j++) begin
			lo = $random(seed);
			hi = $random(seed);
			begin_xfer();
			send_word((j == 0) ? CMD_JOY0 : CMD_JOY1);
			send_word(lo);
			send_word(hi);
			end_xfer();
			exp_joy[j] = {hi, lo};
		end
		st_val = {$random(seed), $random(seed)};
		begin_xfer();
		send_word(CMD_STATUS);
		for (int k = 0; k < 4; k++)
			send_word(st_val[16*k +: 16]);
		end_xfer();
		exp_status = st_val;
		check_regs();

		// configuration string, one character per slot, zero past the end
		begin_xfer();
		read_word(CMD_CONF_STR, 16'h0000);
		for (int k = 1; k <= STRLEN + 1; k++)
			read_word(16'h0000, (k <= STRLEN) ? {8'h00, conf_text[k-1]} : 16'h0000);
		end_xfer();

		// status request raised by the core
		st_val     = {$random(seed), $random(seed)};
		status_in  = st_val;
		status_set = 1'b1;
		repeat (2) @(negedge clk_sys);
		status_set = 1'b0;
		begin_xfer();
		read_word(CMD_STATUS_SET, 16'h00A1);
		for (int k = 0; k < 4; k++)
			read_word(16'h0000, st_val[16*k +: 16]);
		end_xfer();

		// download of three bytes
		begin_xfer();
		send_word(CMD_FILE_TX);
		send_word(16'h00FF);
		end_xfer();
		exp_download = 1'b1;
		check_regs();
		begin_xfer();
		send_word(CMD_FILE_TX_DAT);
		dat_mode = 1'b1;
		for (int k = 0; k < 3; k++) begin
			w        = $random(seed);
			exp_addr = k;
			exp_data = {8'h00, w[7:0]};
			send_word(w);
		end
		dat_mode = 1'b0;
		end_xfer();
		check_regs();
		begin_xfer();
		send_word(CMD_FILE_TX);
		send_word(16'h0000);
		end_xfer();
		exp_download = 1'b0;
		check_regs();

		// file index and extension, extension high half first
		w = $random(seed);
		begin_xfer();
		send_word(CMD_FILE_INDEX);
		send_word(w);
		end_xfer();
		exp_index = w[7:0];
		lo = $random(seed);
		hi = $random(seed);
		begin_xfer();
		send_word(CMD_FILE_INFO);
		send_word(hi);
		send_word(lo);
		end_xfer();
		exp_ext    = {hi, lo};
		ioctl_wait = 1'b1;
		check_regs();
		ioctl_wait = 1'b0;

		// keyboard byte, then a skip word ahead of a byte that must not go out
		b         = $random(seed);
		exp_frame = {1'b1, ~^b, b, 1'b0};
		fork
			recv_kbd_frame(rx_frame);
			begin
				begin_xfer();
				send_word(CMD_KBD);
				send_word({8'h00, b});
				send_word({PS2_SKIP, 8'h00});
				send_word({8'h00, ~b});
				end_xfer();
			end
		join
		frame_chk = 1'b1;
		@(negedge clk_sys);
		frame_chk = 1'b0;
		// last low phase of the frame clock ends first
		@(posedge ps2_kbd_clk_out);
		@(negedge clk_sys);
		quiet_chk = 1'b1;
		repeat (QUIET_CYCLES) @(negedge clk_sys);
		quiet_chk = 1'b0;

		// mouse byte from the host lines, read twice through ps2_host
		b = $random(seed);
		send_mouse_frame(b);
		begin_xfer();
		read_word(CMD_PS2_HOST, 16'h0000);
		read_word(16'h0000, 16'h0000);
		read_word(16'h0000, {7'd0, 1'b1, b});
		end_xfer();
		begin_xfer();
		read_word(CMD_PS2_HOST, 16'h0000);
		read_word(16'h0000, 16'h0000);
		read_word(16'h0000, {7'd0, 1'b0, b});
		end_xfer();

		repeat (2) @(negedge clk_sys);
		$display("summary: %0d errors, %0d bus words sent", errors, words_sent);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d clock cycles", cycles);
		$display("Test failures found");
		$finish;
	end

endmodule

// File: project.f
+incdir+bench
hdl/hps_io_pkg.sv
hdl/hps_cmd_decoder.sv
hdl/ps2_port.sv
hdl/file_loader.sv
hdl/hps_io.sv
bench/tb_hps_io.sv
